/* include/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Instruction word layout, bit 15 down to bit 0
//   [15:14] group, [13:12] skip, [11:10] jump type, [9:8] condition select
//   [7:4] ARGA, [3:0] ARGB, and [7:0] doubles as the 8-bit immediate of a jump

`define GPF_RANGE 15:14      // instruction group field
`define SKIPF_RANGE 13:12    // condition handling, bit 1 applies the condition, bit 0 inverts it
`define JPF_RANGE 11:10      // jump type field
`define CCF_RANGE 9:8        // selects one of the four flags
`define ARGB_RANGE 3:0       // register B index in the low nibble
`define IMM8_RANGE 7:0       // jump immediate byte spans ARGA and ARGB

// group codes, only the jump group is decoded in this slice
`define GROUP_JUMP 2'b10

// jump types as carried in the JPF field
`define JPF_ABS_R 2'b00      // absolute through register B
`define JPF_ABS_U8H 2'b01    // absolute to immediate high byte with base low byte
`define JPF_REL_S8 2'b10     // relative by signed immediate byte
`define JPF_REL_U8H 2'b11    // relative by immediate high byte with base low byte

// operand sources for the B side of the target adder
`define ALUB_SRCX_REG_B 3'b000   // register B value as read
`define ALUB_SRCX_U8H 3'b011     // immediate byte on top of register low byte
`define ALUB_SRCX_S8 3'b100      // sign-extended immediate byte

// where the register B read address comes from
`define REGB_ADDRX_ARGB 2'b00    // ARGB field of the instruction
`define REGB_ADDRX_RB 2'b01      // fixed base register

// the all-zero word stops the machine
`define INSTRUCTION_HALT 16'h0000

// base register that supplies the low byte for the U8H forms
`define REG_RB 4'd1

`endif

/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	typedef logic [15:0] instrT;    // one instruction word
	typedef logic [15:0] wordT;     // data word held in a register
	typedef logic [15:0] addrT;     // program address, one word per step
	typedef logic [3:0] regAddrT;   // index into the 16-entry register file
	typedef logic [3:0] flagsT;     // condition flags indexed by the 2-bit select

	// four phases of every instruction, in the order they run
	typedef enum logic [1:0] {
		phaseFetch = 2'd0,      // instruction word is sampled at the end of this cycle
		phaseDecode = 2'd1,     // decoder output settles from the latched word
		phaseExecute = 2'd2,    // operand and target are formed
		phaseCommit = 2'd3      // pc is written at the end of this cycle
	} phaseT;

	// everything the branch unit needs from the jump decoder
	typedef struct packed {
		logic pcEnable;         // low only for HALT so pc holds
		logic isJump;           // unconditional jump
		logic ccApply;          // jump depends on the selected flag
		logic ccInvert;         // take the jump when the flag is clear instead
		logic [1:0] ccSelect;   // which of the four flags is tested
		logic relative;         // target is pc plus operand rather than the operand itself
		logic [1:0] regBAddrSel;    // ARGB field or base register as read address
		logic [2:0] aluBSrc;    // how the jump operand is built
	} jumpCtrlT;

endpackage

`default_nettype wire

/* verilog/phaseSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module phaseSequencer import cpuPkg::*; (
	input wire logic CLK,
	input wire logic reset,
	input wire logic haltReq,       // decoder saw the HALT word
	output logic fetch,             // high while the next word is sampled
	output logic decode,
	output logic execute,
	output logic commit,            // pc update cycle
	output logic halted             // stays set until reset once HALT commits
);

	phaseT phase;                   // current position in the four-phase ring

	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= phaseFetch;    // every run starts by fetching from pc 0
			halted <= 1'b0;
		end else if (!halted) begin // a halted machine parks in fetch
			case (phase)
				phaseFetch: phase <= phaseDecode;
				phaseDecode: phase <= phaseExecute;
				phaseExecute: phase <= phaseCommit;
				phaseCommit: begin
					phase <= phaseFetch;    // wrap to the next instruction
					halted <= haltReq;      // HALT is only honoured at its own commit
				end
				default: phase <= phaseFetch;
			endcase
		end
	end

	// strobes are plain decodes of the phase register
	assign fetch = (phase == phaseFetch) && !halted;    // masked so no new word is taken
	assign decode = (phase == phaseDecode);
	assign execute = (phase == phaseExecute);
	assign commit = (phase == phaseCommit);

endmodule

`default_nettype wire

/* verilog/jumpGroupDecoder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module jumpGroupDecoder import cpuPkg::*; (
	input wire instrT instruction,  // latched instruction word
	output jumpCtrlT ctrl           // pc and operand control for the branch unit
);

	logic [1:0] groupField;         // instruction group
	logic [1:0] skipField;          // condition handling bits
	logic [1:0] jumpType;           // one of the four jump forms
	logic [1:0] ccField;            // flag select

	assign groupField = instruction[`GPF_RANGE];
	assign skipField = instruction[`SKIPF_RANGE];
	assign jumpType = instruction[`JPF_RANGE];
	assign ccField = instruction[`CCF_RANGE];

	always_comb begin
		ctrl = '0;                  // quiet control unless a field below sets it

		// invert and select are plain field copies, they only matter with ccApply
		ctrl.ccInvert = skipField[0];
		ctrl.ccSelect = ccField;

		// outside the jump group nothing is ever taken
		if (groupField == `GROUP_JUMP) begin
			ctrl.isJump = ~skipField[1];    // skip bit clear means always jump
			ctrl.ccApply = skipField[1];    // skip bit set makes the jump conditional
		end

		// every word but HALT moves the pc on
		if (instruction == `INSTRUCTION_HALT) begin
			ctrl.pcEnable = 1'b0;
		end else begin
			ctrl.pcEnable = 1'b1;
		end

		// jump type picks the operand source, the register read address and the mode
		case (jumpType)
			`JPF_ABS_R: begin
				ctrl.aluBSrc = `ALUB_SRCX_REG_B;    // full register value is the target
				ctrl.regBAddrSel = `REGB_ADDRX_ARGB;
				ctrl.relative = 1'b0;
			end

			`JPF_ABS_U8H: begin
				ctrl.aluBSrc = `ALUB_SRCX_U8H;      // immediate high byte, base low byte
				ctrl.regBAddrSel = `REGB_ADDRX_RB;
				ctrl.relative = 1'b0;
			end

			`JPF_REL_S8: begin
				ctrl.aluBSrc = `ALUB_SRCX_S8;       // short signed hop from this word
				ctrl.regBAddrSel = `REGB_ADDRX_ARGB;
				ctrl.relative = 1'b1;
			end

			`JPF_REL_U8H: begin
				ctrl.aluBSrc = `ALUB_SRCX_U8H;      // long hop built like the absolute form
				ctrl.regBAddrSel = `REGB_ADDRX_RB;
				ctrl.relative = 1'b1;
			end

			default: begin
				ctrl.aluBSrc = `ALUB_SRCX_REG_B;
				ctrl.regBAddrSel = `REGB_ADDRX_ARGB;
				ctrl.relative = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile import cpuPkg::*; (
	input wire logic CLK,
	input wire logic reset,
	input wire logic writeEnable,       // write strobe, sampled at the clock edge
	input wire regAddrT writeAddr,
	input wire wordT writeData,
	input wire regAddrT readAddr,       // driven by the branch unit
	output wordT readData               // follows readAddr in the same cycle
);

	wordT regs [16];                    // sixteen general registers

	// one write port, registers all come up as zero
	always_ff @(posedge CLK) begin
		if (reset) begin
			foreach (regs[i]) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;   // a write lands at the edge it is seen
		end
	end

	// read is a plain mux so decode to operand takes no cycle
	assign readData = regs[readAddr];

endmodule

`default_nettype wire

/* verilog/branchUnit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module branchUnit import cpuPkg::*; (
	input wire logic CLK,
	input wire logic reset,
	input wire jumpCtrlT ctrl,          // from the jump decoder
	input wire instrT instruction,      // latched word, source of ARGB and the immediate
	input wire flagsT flags,            // condition flags from outside the slice
	input wire logic commit,            // pc is only written in this phase
	output regAddrT regBAddr,           // register file read address
	input wire wordT regBData,          // value read at regBAddr
	output addrT pc,                    // address of the instruction in flight
	output logic jumpTaken              // high for the commit cycle of a taken jump
);

	logic [7:0] imm8;                   // jump immediate byte
	wordT operand;                      // B side of the target computation
	addrT target;                       // where a taken jump goes
	logic flagBit;                      // the flag picked by ccSelect
	logic taken;                        // jump decision for the current word

	assign imm8 = instruction[`IMM8_RANGE];

	// U8H forms always read the base register, the others read ARGB
	always_comb begin
		if (ctrl.regBAddrSel == `REGB_ADDRX_RB) begin
			regBAddr = `REG_RB;
		end else begin
			regBAddr = instruction[`ARGB_RANGE];
		end
	end

	// build the operand the way the ALU B mux would
	always_comb begin
		case (ctrl.aluBSrc)
			`ALUB_SRCX_REG_B: operand = regBData;   // register as it stands
			`ALUB_SRCX_U8H: operand = {imm8, regBData[7:0]};    // immediate over base low byte
			`ALUB_SRCX_S8: operand = {{8{imm8[7]}}, imm8};      // sign-extend the byte
			default: operand = regBData;
		endcase
	end

	// relative targets count from the jump's own address
	assign target = ctrl.relative ? addrT'(pc + operand) : addrT'(operand);

	// condition test, invert flips the sense of the chosen flag
	assign flagBit = flags[ctrl.ccSelect];
	assign taken = ctrl.isJump || (ctrl.ccApply && (flagBit ^ ctrl.ccInvert));

	assign jumpTaken = commit && taken;  // only visible while the pc is being written

	// pc moves once per instruction, at the edge that ends commit
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;                   // execution starts at address zero
		end else if (commit) begin
			if (taken) begin
				pc <= target;
			end else if (ctrl.pcEnable) begin
				pc <= pc + addrT'(1);   // fall through to the next word
			end
			// HALT leaves pc where it is
		end
	end

endmodule

`default_nettype wire

/* verilog/jumpCore.sv */
`timescale 1ns/1ns
`default_nettype none

module jumpCore import cpuPkg::*; (
	input wire logic CLK,
	input wire logic reset,
	input wire instrT instruction,      // held stable by the source while fetch is high
	input wire flagsT flags,
	input wire logic regWrite,          // register preload strobe
	input wire regAddrT regWriteAddr,
	input wire wordT regWriteData,
	output logic fetch,                 // source presents the next word while this is high
	output addrT pc,
	output logic jumpTaken,
	output logic halted
);

	instrT instrReg;                    // word being worked on for the remaining phases
	logic commit;                       // pc write phase
	jumpCtrlT jumpCtrl;                 // decoded jump control
	regAddrT regBAddr;                  // register B read address from the branch unit
	wordT regBData;                     // register B read data

	// capture the word at the end of fetch, it stays put until the next fetch
	always_ff @(posedge CLK) begin
		if (fetch) begin
			instrReg <= instruction;
		end
	end

	phaseSequencer i_phaseSequencer (
		.CLK(CLK),
		.reset(reset),
		.haltReq(~jumpCtrl.pcEnable),   // HALT is the one word that disables the pc
		.fetch(fetch),
		.decode(),                      // no decode or execute work lives in this slice
		.execute(),
		.commit(commit),
		.halted(halted)
	);

	jumpGroupDecoder i_jumpGroupDecoder (
		.instruction(instrReg),
		.ctrl(jumpCtrl)
	);

	registerFile i_registerFile (
		.CLK(CLK),
		.reset(reset),
		.writeEnable(regWrite),         // preload path only, no ALU writeback here
		.writeAddr(regWriteAddr),
		.writeData(regWriteData),
		.readAddr(regBAddr),
		.readData(regBData)
	);

	branchUnit i_branchUnit (
		.CLK(CLK),
		.reset(reset),
		.ctrl(jumpCtrl),
		.instruction(instrReg),
		.flags(flags),
		.commit(commit),
		.regBAddr(regBAddr),
		.regBData(regBData),
		.pc(pc),
		.jumpTaken(jumpTaken)
	);

endmodule

`default_nettype wire

/* bench/jumpCore_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module jumpCore_tb import cpuPkg::*; ();

	localparam int maxEntries = 64;     // room for every non-comment line of the test file

	logic clk;
	logic reset;
	instrT instruction;
	flagsT flags;
	logic regWrite;
	regAddrT regWriteAddr;
	wordT regWriteData;
	logic fetch;
	addrT pc;
	logic jumpTaken;
	logic halted;

	byte entryKind [maxEntries];                // R preload, S step or H halt
	logic [8*16-1:0] entryName [maxEntries];    // test name as read from the file
	instrT entryInstr [maxEntries];
	flagsT entryFlags [maxEntries];
	addrT entryPc [maxEntries];                 // pc expected at the fetch after commit
	logic entryTaken [maxEntries];              // jumpTaken expected during commit
	regAddrT entryReg [maxEntries];
	wordT entryValue [maxEntries];
	int entryCount;

	regAddrT preloadAddr [$];           // preloads wait here for the next fetch
	wordT preloadData [$];
	addrT lastPc;                       // pc left by the most recent step and kept by HALT
	int errorCount;
	int checkCount;
	int cycleCount = 0;
	int cycleLimit = 100000;            // replaced once the test file length is known

	jumpCore i_dut (
		.CLK(clk),
		.reset(reset),
		.instruction(instruction),
		.flags(flags),
		.regWrite(regWrite),
		.regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData),
		.fetch(fetch),
		.pc(pc),
		.jumpTaken(jumpTaken),
		.halted(halted)
	);

	always #2 clk = ~clk;               // 4 ns period

	// the run is bounded by the length of the tests
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout after %0d cycles, the DUT never came back to fetch", cycleCount);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic checkTaken(input logic [8*16-1:0] name, input logic expected,
			input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %0s: expected jumpTaken %b, got %b", name, expected, actual);
		end
	endtask

	task automatic checkPc(input logic [8*16-1:0] name, input addrT expected,
			input addrT actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %0s: expected pc %h, got %h", name, expected, actual);
		end
	endtask

	task automatic checkHalted(input logic [8*16-1:0] name, input logic expected,
			input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %0s: expected halted %b, got %b", name, expected, actual);
		end
	endtask

	task automatic checkFetch(input logic [8*16-1:0] name, input logic expected,
			input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error %0s: expected fetch %b, got %b", name, expected, actual);
		end
	endtask

	// every line is read up front so the cycle limit can follow the file length
	task automatic readTests();
		int fd;
		int code;
		logic [8*16-1:0] token;
		logic [8*128-1:0] lineText;
		logic [31:0] fieldA;
		logic [31:0] fieldB;
		logic [31:0] fieldC;
		logic [31:0] fieldD;
		fd = $fopen("bench/jump_tests.txt", "r");
		entryCount = 0;
		if (fd == 0) begin
			errorCount++;
			$display("could not open bench/jump_tests.txt");
		end else begin
			while (!$feof(fd) && entryCount < maxEntries) begin
				code = $fscanf(fd, "%s", token);
				if (code != 1) break;
				if (token == "#") begin
					code = $fgets(lineText, fd);    // drop the rest of a comment line
				end else if (token == "R") begin
					code = $fscanf(fd, "%h %h", fieldA, fieldB);
					entryKind[entryCount] = "R";
					entryReg[entryCount] = regAddrT'(fieldA);
					entryValue[entryCount] = wordT'(fieldB);
					entryCount++;
				end else if (token == "S") begin
					code = $fscanf(fd, "%s %h %h %h %h", token, fieldA, fieldB,
						fieldC, fieldD);
					entryKind[entryCount] = "S";
					entryName[entryCount] = token;
					entryInstr[entryCount] = instrT'(fieldA);
					entryFlags[entryCount] = flagsT'(fieldB);
					entryPc[entryCount] = addrT'(fieldC);
					entryTaken[entryCount] = fieldD[0];
					entryCount++;
				end else if (token == "H") begin
					code = $fscanf(fd, "%s", token);
					entryKind[entryCount] = "H";
					entryName[entryCount] = token;
					entryCount++;
				end else begin
					errorCount++;
					$display("test file holds a line of unknown kind %0s", token);
				end
			end
			$fclose(fd);
		end
	endtask

	// called at a falling edge, returns at the first falling edge with fetch high
	task automatic waitForFetch();
		while (fetch !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	task automatic runStep(input int idx);
		waitForFetch();
		instruction = entryInstr[idx];  // held until the next fetch
		flags = entryFlags[idx];        // held through commit where the condition is tested
		if (preloadAddr.size() > 0) begin
			regWrite = 1'b1;            // lands at the edge that ends fetch
			regWriteAddr = preloadAddr.pop_front();
			regWriteData = preloadData.pop_front();
		end
		@(negedge clk);                 // decode
		regWrite = 1'b0;
		checkTaken(entryName[idx], 1'b0, jumpTaken);
		checkFetch(entryName[idx], 1'b0, fetch);
		@(negedge clk);                 // execute
		checkTaken(entryName[idx], 1'b0, jumpTaken);
		checkFetch(entryName[idx], 1'b0, fetch);
		@(negedge clk);                 // commit
		checkTaken(entryName[idx], entryTaken[idx], jumpTaken);
		checkFetch(entryName[idx], 1'b0, fetch);
		@(negedge clk);                 // next fetch shows the committed pc
		checkPc(entryName[idx], entryPc[idx], pc);
		checkHalted(entryName[idx], 1'b0, halted);
		checkFetch(entryName[idx], 1'b1, fetch);   // the ring is back after four cycles
		checkTaken(entryName[idx], 1'b0, jumpTaken);
		lastPc = entryPc[idx];
	endtask

	task automatic runHalt(input int idx);
		int k;
		waitForFetch();
		instruction = `INSTRUCTION_HALT;
		flags = '0;
		repeat (3) @(negedge clk);      // on to commit
		checkTaken(entryName[idx], 1'b0, jumpTaken);
		@(negedge clk);
		checkPc(entryName[idx], lastPc, pc);
		checkHalted(entryName[idx], 1'b1, halted);
		checkFetch(entryName[idx], 1'b0, fetch);
		// the machine must stay parked, with no further fetch or pc movement
		for (k = 0; k < 8; k++) begin
			@(negedge clk);
			checkPc(entryName[idx], lastPc, pc);
			checkFetch(entryName[idx], 1'b0, fetch);
			checkHalted(entryName[idx], 1'b1, halted);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instruction = '0;
		flags = '0;
		regWrite = 1'b0;
		regWriteAddr = '0;
		regWriteData = '0;
		errorCount = 0;
		checkCount = 0;
		lastPc = '0;
		readTests();
		cycleLimit = entryCount * 4 + 50;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		checkPc("after_reset", '0, pc);             // reset state is visible right away
		checkTaken("after_reset", 1'b0, jumpTaken);
		checkHalted("after_reset", 1'b0, halted);
		checkFetch("after_reset", 1'b1, fetch);
		for (int i = 0; i < entryCount; i++) begin
			case (entryKind[i])
				"R": begin
					preloadAddr.push_back(entryReg[i]);
					preloadData.push_back(entryValue[i]);
				end
				"S": runStep(i);
				"H": runHalt(i);
				default: errorCount++;
			endcase
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/jump_tests.txt */
# R regIndex value | S name instruction flags expectedPc expectedTaken | H name
# one preload is written at the fetch of the next S line, all fields in hex
S alu_add 1234 0 0001 0
S alu_mix 4321 f 0002 0
R 5 0040
S jp_reg 8005 0 0040 1
R 1 00a7
S jp_u8h 8412 0 12a7 1
S jr_neg 88f0 0 1297 1
S jr_pos 8830 0 12c7 1
R 1 0003
S jr_u8h 8c01 0 13ca 1
S cc0_set a810 1 13da 1
S cc0_clr a810 e 13db 0
S cc1_set a910 2 13eb 1
S cc1_clr a910 d 13ec 0
S cc2_set aa10 4 13fc 1
S cc2_clr aa10 b 13fd 0
S cc3_set ab10 8 140d 1
S cc3_clr ab10 7 140e 0
S ncc0_clr b810 e 141e 1
S ncc0_set b810 1 141f 0
S ncc1_clr b910 d 142f 1
S ncc1_set b910 2 1430 0
S ncc2_clr ba10 b 1440 1
S ncc2_set ba10 4 1441 0
S ncc3_clr bb10 7 1451 1
S ncc3_set bb10 8 1452 0
S alu_tail c0ff 0 1453 0
H halt_end

/* sources.f */
+incdir+include
verilog/cpuPkg.sv
verilog/phaseSequencer.sv
verilog/jumpGroupDecoder.sv
verilog/registerFile.sv
verilog/branchUnit.sv
verilog/jumpCore.sv
bench/jumpCore_tb.sv
